/* verilog/trace_cfg.svh */
/*
 * build-time sizes of the trace unit
 * included by the packages and by every module that sizes a vector
 */
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// data and address width of the observed core
`define TRACE_XLEN 32

// general purpose register count, index width follows from it
`define TRACE_GNUM 32
`define TRACE_GLOG $clog2(`TRACE_GNUM)

// records held in the FIFO, power of two only
`define TRACE_FIFO_DEPTH 8
`define TRACE_FIFO_ALOG  $clog2(`TRACE_FIFO_DEPTH)

`endif

/* verilog/tcb_pkg.sv */
/*
 * payload types of the observed core buses
 * shared by the bus interface and the record builder
 */
`include "trace_cfg.svh"

package tcb_pkg;

    // request, sampled on the edge where vld and rdy are both high
    typedef struct packed {
        logic                   wen;  // write enable
        logic                   ren;  // read enable
        logic [`TRACE_XLEN-1:0] adr;  // byte address
        logic [1:0]             siz;  // log2 of bytes
        logic [`TRACE_XLEN-1:0] wdt;  // write data
    } tcb_req_t;

    // response, valid one cycle after the transfer
    typedef struct packed {
        logic [`TRACE_XLEN-1:0] rdt;  // read data
    } tcb_rsp_t;

endpackage: tcb_pkg

/* verilog/trace_pkg.sv */
/*
 * trace record layout and host register map
 * the instruction word is seen both as a 32-bit and as a 16-bit encoding
 */
`include "trace_cfg.svh"

package trace_pkg;

    // 32-bit encoding
    typedef struct packed {
        logic [16:0] rest;    // rs1, rs2, funct7 or immediate
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;  // low two bits are 11 for 32-bit
    } ins_full_t;

    // 16-bit encoding in the low halfword
    typedef struct packed {
        logic [15:0] hi;      // next halfword, not decoded
        logic [2:0]  funct3;
        logic [10:0] mid;     // register and immediate bits
        logic [1:0]  op;      // quadrant
    } ins_cmp_t;

    typedef union packed {
        ins_full_t full;
        ins_cmp_t  cmp;
    } ins_word_u;

    // record word 5
    typedef struct packed {
        logic [`TRACE_XLEN-8-2*`TRACE_GLOG-1:0] pad;
        logic [`TRACE_GLOG-1:0] ls_sid;  // store source register
        logic [1:0]             ls_siz;
        logic                   ls_ren;
        logic                   ls_wen;
        logic                   ls_ena;
        logic [`TRACE_GLOG-1:0] wb_idx;
        logic                   wb_ena;
        logic                   mem;     // load or store instruction
        logic                   siz32;   // 32-bit encoding
    } trace_flg_t;

    // one record, six words
    typedef struct packed {
        trace_flg_t             flg;     // word 5
        logic [`TRACE_XLEN-1:0] ls_dat;  // word 4
        logic [`TRACE_XLEN-1:0] ls_adr;  // word 3
        logic [`TRACE_XLEN-1:0] wb_dat;  // word 2
        logic [`TRACE_XLEN-1:0] ins;     // word 1
        logic [`TRACE_XLEN-1:0] pc;      // word 0
    } trace_rec_t;

    // host word index
    typedef enum logic [2:0] {
        REC0   = 3'd0,
        REC1   = 3'd1,
        REC2   = 3'd2,
        REC3   = 3'd3,
        REC4   = 3'd4,
        REC5   = 3'd5,
        STATUS = 3'd6,
        POP    = 3'd7
    } trace_reg_e;

endpackage: trace_pkg

/* verilog/tcb_if.sv */
/*
 * observed bus with valid/ready handshake
 * the trace unit only ever connects through the mon modport
 */
`timescale 1ns/1ns

interface tcb_if import tcb_pkg::*; (
    input logic clk
);

    logic     vld;  // manager request valid
    logic     rdy;  // subordinate ready
    tcb_req_t req;
    tcb_rsp_t rsp;  // one cycle behind the transfer
    logic     trn;  // transfer on this edge

    assign trn = vld & rdy;

    modport man (
        input  clk, rdy, rsp, trn,
        output vld, req
    );

    modport sub (
        input  clk, vld, req, trn,
        output rdy, rsp
    );

    // passive observer
    modport mon (
        input clk, vld, rdy, req, rsp, trn
    );

endinterface: tcb_if

/* verilog/trace_fetch_stage.sv */
/*
 * instruction fetch alignment
 * pairs the fetch address with its late instruction data and classifies it
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_fetch_stage import trace_pkg::*; (
    input  logic                   tcb_ifu,
    input  logic                   rst_n,
    tcb_if.mon                     ifu,
    output logic                   vld,    // record slot, 2 cycles after transfer
    output logic [`TRACE_XLEN-1:0] pc,
    output ins_word_u              ins,
    output logic                   siz32,
    output logic                   mem
);

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [2:0] C_LW      = 3'b010;
    localparam logic [2:0] C_SW      = 3'b110;

    logic                   trn_q;  // transfer seen last edge
    logic [`TRACE_XLEN-1:0] adr_q;  // address waiting for its data

    ////////////////////////////////////////////////////////////////////////////
    // two-stage pipe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            trn_q <= 1'b0;
            vld   <= 1'b0;
        end else begin
            trn_q <= ifu.trn;
            vld   <= trn_q;  // data arrived this cycle
        end
    end

    // payload, no reset
    always_ff @(posedge tcb_ifu) begin
        if (ifu.trn) adr_q <= ifu.req.adr;
        if (trn_q) begin
            pc  <= adr_q;
            ins <= ifu.rsp.rdt;
        end
    end

    // decode
    assign siz32 = (ins.full.opcode[1:0] == 2'b11);

    always_comb begin
        if (siz32) begin
            mem = (ins.full.opcode == OPC_LOAD) || (ins.full.opcode == OPC_STORE);
        end else begin
            // quadrant 0, c.lw / c.sw
            mem = (ins.cmp.op == 2'b00) &&
                  ((ins.cmp.funct3 == C_LW) || (ins.cmp.funct3 == C_SW));
        end
    end

endmodule: trace_fetch_stage

/* verilog/trace_record_builder.sv */
/*
 * record assembly
 * merges the aligned fetch with write-back and the preceding load/store transfer
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_record_builder import tcb_pkg::*; import trace_pkg::*; (
    input  logic                   tcb_ifu,
    input  logic                   rst_n,
    // aligned fetch
    input  logic                   vld,
    input  logic [`TRACE_XLEN-1:0] pc,
    input  ins_word_u              ins,
    input  logic                   siz32,
    input  logic                   mem,
    // load/store bus
    tcb_if.mon                     lsu,
    // register write-back
    input  logic                   gpr_den,
    input  logic [`TRACE_GLOG-1:0] gpr_did,
    input  logic [`TRACE_XLEN-1:0] gpr_ddt,
    input  logic [`TRACE_GLOG-1:0] gpr_sid,
    // to FIFO
    output logic                   push,
    output trace_rec_t             rec
);

    logic                   ls_trn_q;  // load/store transfer last cycle
    tcb_req_t               ls_req_q;
    logic [`TRACE_GLOG-1:0] ls_sid_q;  // store source register
    trace_rec_t             rec_d;

    ////////////////////////////////////////////////////////////////////////////
    // one cycle of load/store history
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            ls_trn_q <= 1'b0;
        end else begin
            ls_trn_q <= lsu.trn;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        ls_req_q <= lsu.req;
        ls_sid_q <= gpr_sid;
    end

    ////////////////////////////////////////////////////////////////////////////
    // record
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rec_d           = '0;
        rec_d.pc        = pc;
        rec_d.ins       = ins;
        rec_d.flg.siz32 = siz32;
        rec_d.flg.mem   = mem;
        // write-back in the same cycle
        if (gpr_den) begin
            rec_d.wb_dat     = gpr_ddt;
            rec_d.flg.wb_ena = 1'b1;
            rec_d.flg.wb_idx = gpr_did;
        end
        // load/store from the edge before, load data is on rsp now
        if (ls_trn_q) begin
            rec_d.ls_adr     = ls_req_q.adr;
            rec_d.ls_dat     = ls_req_q.wen ? ls_req_q.wdt : lsu.rsp.rdt;
            rec_d.flg.ls_ena = 1'b1;
            rec_d.flg.ls_wen = ls_req_q.wen;
            rec_d.flg.ls_ren = ls_req_q.ren;
            rec_d.flg.ls_siz = ls_req_q.siz;
            if (ls_req_q.wen) rec_d.flg.ls_sid = ls_sid_q;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= vld;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (vld) rec <= rec_d;  // held until the next fetch
    end

endmodule: trace_record_builder

/* verilog/trace_fifo.sv */
/*
 * record FIFO
 * drops records when full and counts the drops, head is read without a pop
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_fifo import trace_pkg::*; (
    input  logic                        tcb_ifu,
    input  logic                        rst_n,
    input  logic                        push,
    input  trace_rec_t                  wdata,
    input  logic                        pop,
    output trace_rec_t                  head,
    output logic                        empty,
    output logic [`TRACE_FIFO_ALOG:0]   count,
    output logic [15:0]                 ovf    // dropped records, saturating
);

    localparam int unsigned DEPTH = `TRACE_FIFO_DEPTH;
    localparam int unsigned ALOG  = `TRACE_FIFO_ALOG;

    trace_rec_t      mem_q [DEPTH];
    logic [ALOG:0]   wr_ptr;  // extra msb tells full from empty
    logic [ALOG:0]   rd_ptr;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign count = wr_ptr - rd_ptr;
    assign empty = (count == '0);
    assign full  = (count == (ALOG+1)'(DEPTH));

    assign do_pop  = pop & ~empty;           // pop on empty ignored
    assign do_push = push & (~full | do_pop);  // a slot frees this edge

    ////////////////////////////////////////////////////////////////////////////
    // pointers and drop counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ovf    <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !do_push && (ovf != '1)) begin
                ovf <= ovf + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge tcb_ifu) begin
        if (do_push) mem_q[wr_ptr[ALOG-1:0]] <= wdata;
    end

    assign head = mem_q[rd_ptr[ALOG-1:0]];  // stale when empty

endmodule: trace_fifo

/* verilog/trace_wb_port.sv */
/*
 * Wishbone classic host port
 * word reads of the head record and status, a write to POP drops the head
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_wb_port import trace_pkg::*; (
    input  logic                      tcb_ifu,
    input  logic                      rst_n,
    // Wishbone slave
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [2:0]                wb_adr,    // word index
    input  logic [`TRACE_XLEN-1:0]    wb_dat_w,  // don't care, any write pops
    output logic [`TRACE_XLEN-1:0]    wb_dat_r,
    output logic                      wb_ack,
    // FIFO side
    input  trace_rec_t                head,
    input  logic                      empty,
    input  logic [`TRACE_FIFO_ALOG:0] count,
    input  logic [15:0]               ovf,
    output logic                      pop
);

    trace_reg_e             reg_idx;
    logic                   req;     // access start, one per ack
    logic [`TRACE_XLEN-1:0] rd_mux;

    assign reg_idx = trace_reg_e'(wb_adr);
    assign req     = wb_cyc & wb_stb & ~wb_ack;

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            pop    <= 1'b0;
        end else begin
            wb_ack <= req;
            pop    <= req & wb_we & (reg_idx == POP);  // lands with ack
        end
    end

    // read mux
    always_comb begin
        case (reg_idx)
            REC0:    rd_mux = head.pc;
            REC1:    rd_mux = head.ins;
            REC2:    rd_mux = head.wb_dat;
            REC3:    rd_mux = head.ls_adr;
            REC4:    rd_mux = head.ls_dat;
            REC5:    rd_mux = head.flg;
            STATUS:  rd_mux = {8'h00, ovf, 8'(count)};
            default: rd_mux = '0;  // POP reads as zero
        endcase
        if (empty && (reg_idx < STATUS)) rd_mux = '0;  // no record
    end

    always_ff @(posedge tcb_ifu) begin
        if (req && !wb_we) wb_dat_r <= rd_mux;
    end

endmodule: trace_wb_port

/* verilog/trace_unit_top.sv */
/*
 * execution trace unit top level
 * plain core and host ports, bus monitors are built here from the core signals
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_unit_top import trace_pkg::*; (
    input  logic                   tcb_ifu,
    input  logic                   rst_n,
    // instruction fetch
    input  logic                   ifu_vld,
    input  logic                   ifu_rdy,
    input  logic [`TRACE_XLEN-1:0] ifu_adr,
    input  logic [`TRACE_XLEN-1:0] ifu_rdt,
    // load/store
    input  logic                   lsu_vld,
    input  logic                   lsu_rdy,
    input  logic                   lsu_wen,
    input  logic                   lsu_ren,
    input  logic [`TRACE_XLEN-1:0] lsu_adr,
    input  logic [1:0]             lsu_siz,
    input  logic [`TRACE_XLEN-1:0] lsu_wdt,
    input  logic [`TRACE_XLEN-1:0] lsu_rdt,
    // register write-back
    input  logic                   gpr_den,
    input  logic [`TRACE_GLOG-1:0] gpr_did,
    input  logic [`TRACE_XLEN-1:0] gpr_ddt,
    input  logic [`TRACE_GLOG-1:0] gpr_sid,
    // host
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [2:0]             wb_adr,
    input  logic [`TRACE_XLEN-1:0] wb_dat_w,
    output logic [`TRACE_XLEN-1:0] wb_dat_r,
    output logic                   wb_ack
);

    logic                      fs_vld;
    logic [`TRACE_XLEN-1:0]    fs_pc;
    ins_word_u                 fs_ins;
    logic                      fs_siz32;
    logic                      fs_mem;
    logic                      push;
    trace_rec_t                rec;
    trace_rec_t                head;
    logic                      empty;
    logic [`TRACE_FIFO_ALOG:0] count;
    logic [15:0]               ovf;
    logic                      pop;

    ////////////////////////////////////////////////////////////////////////////
    // bus monitors, both on the core clock
    ////////////////////////////////////////////////////////////////////////////

    tcb_if ifu_mon (.clk (tcb_ifu));
    tcb_if lsu_mon (.clk (tcb_ifu));

    // fetch is a word read
    assign ifu_mon.vld = ifu_vld;
    assign ifu_mon.rdy = ifu_rdy;
    assign ifu_mon.req = '{wen: 1'b0, ren: 1'b1, adr: ifu_adr, siz: 2'd2, wdt: '0};
    assign ifu_mon.rsp = '{rdt: ifu_rdt};

    assign lsu_mon.vld = lsu_vld;
    assign lsu_mon.rdy = lsu_rdy;
    assign lsu_mon.req = '{wen: lsu_wen, ren: lsu_ren, adr: lsu_adr, siz: lsu_siz,
                           wdt: lsu_wdt};
    assign lsu_mon.rsp = '{rdt: lsu_rdt};

    trace_fetch_stage i_fetch (
        .tcb_ifu (tcb_ifu), .rst_n (rst_n), .ifu (ifu_mon),
        .vld (fs_vld), .pc (fs_pc), .ins (fs_ins), .siz32 (fs_siz32), .mem (fs_mem)
    );

    trace_record_builder i_builder (
        .tcb_ifu (tcb_ifu), .rst_n (rst_n),
        .vld (fs_vld), .pc (fs_pc), .ins (fs_ins), .siz32 (fs_siz32), .mem (fs_mem),
        .lsu (lsu_mon),
        .gpr_den (gpr_den), .gpr_did (gpr_did), .gpr_ddt (gpr_ddt), .gpr_sid (gpr_sid),
        .push (push), .rec (rec)
    );

    trace_fifo i_fifo (
        .tcb_ifu (tcb_ifu), .rst_n (rst_n), .push (push), .wdata (rec), .pop (pop),
        .head (head), .empty (empty), .count (count), .ovf (ovf)
    );

    trace_wb_port i_wb (
        .tcb_ifu (tcb_ifu), .rst_n (rst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .head (head), .empty (empty), .count (count), .ovf (ovf), .pop (pop)
    );

endmodule: trace_unit_top

/* tests/trace_unit_props.sv */
/*
 * Wishbone handshake and FIFO occupancy rules
 * bound into the FIFO and the Wishbone port, each instance ties off the other side
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_unit_props (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      wb_cyc,
    input logic                      wb_stb,
    input logic                      wb_ack,
    input logic                      push,
    input logic                      full,
    input logic [`TRACE_FIFO_ALOG:0] count
);

    localparam logic [`TRACE_FIFO_ALOG:0] DEPTH = (`TRACE_FIFO_ALOG+1)'(`TRACE_FIFO_DEPTH);

    // ack needs a request on the edge before
    ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("Wishbone ack without cyc and stb on the previous edge");

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack
    ) else $error("Wishbone ack held longer than one cycle");

    count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= DEPTH
    ) else $error("FIFO count above depth");

    // dropped record, or push and pop in the same edge
    full_push_keeps_count: assert property (
        @(posedge clk) disable iff (!rst_n) push && full |=> count == $past(count)
    ) else $error("push into a full FIFO changed the count");

endmodule: trace_unit_props

bind trace_fifo trace_unit_props i_fifo_props (
    .clk    (tcb_ifu),
    .rst_n  (rst_n),
    .wb_cyc (1'b0),
    .wb_stb (1'b0),
    .wb_ack (1'b0),
    .push   (push),
    .full   (full),
    .count  (count)
);

bind trace_wb_port trace_unit_props i_wb_props (
    .clk    (tcb_ifu),
    .rst_n  (rst_n),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .push   (1'b0),
    .full   (1'b0),
    .count  ('0)
);

/* tests/trace_unit_tb.sv */
/*
 * trace unit testbench
 * replays golden fetch, load/store and write-back vectors, reads records back over Wishbone
 */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_unit_tb import trace_pkg::*;;

    localparam int NVEC   = 14;              // vectors in the golden file
    localparam int VWORDS = 13;              // 7 stimulus words, 6 record words
    localparam int NSOLO  = 4;               // vectors checked one by one
    localparam int NFILL  = NVEC - NSOLO;    // fetches that overrun the FIFO
    localparam int LIMIT  = NVEC*40 + 500;   // watchdog, in cycles
    localparam logic [31:0] FILL_STATUS  = 32'(((NFILL - `TRACE_FIFO_DEPTH) << 8) |
                                                `TRACE_FIFO_DEPTH);
    localparam logic [31:0] DRAIN_STATUS = 32'((NFILL - `TRACE_FIFO_DEPTH) << 8);

    logic                   tcb_ifu;
    logic                   rst_n;
    logic                   ifu_vld;
    logic                   ifu_rdy;
    logic [`TRACE_XLEN-1:0] ifu_adr;
    logic [`TRACE_XLEN-1:0] ifu_rdt;
    logic                   lsu_vld;
    logic                   lsu_rdy;
    logic                   lsu_wen;
    logic                   lsu_ren;
    logic [`TRACE_XLEN-1:0] lsu_adr;
    logic [1:0]             lsu_siz;
    logic [`TRACE_XLEN-1:0] lsu_wdt;
    logic [`TRACE_XLEN-1:0] lsu_rdt;
    logic                   gpr_den;
    logic [`TRACE_GLOG-1:0] gpr_did;
    logic [`TRACE_XLEN-1:0] gpr_ddt;
    logic [`TRACE_GLOG-1:0] gpr_sid;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [2:0]             wb_adr;
    logic [`TRACE_XLEN-1:0] wb_dat_w;
    logic [`TRACE_XLEN-1:0] wb_dat_r;
    logic                   wb_ack;

    logic [31:0] golden [NVEC*VWORDS];
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_err0;   // error count when the current test began
    string       names [NSOLO] = '{"decode_32", "decode_16_wb", "store", "load"};

    trace_unit_top i_trace_unit_top (.*);

    always #2 tcb_ifu = ~tcb_ifu;  // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // one classic cycle, returns once ack is seen
    task automatic wb_access(input logic we, input logic [2:0] adr, output logic [31:0] dat);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = 32'h0;
        do begin
            @(posedge tcb_ifu);
            #1;
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            errors++;
            $display("no Wishbone ack within 16 cycles for word %0d", adr);
        end
        dat    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic pop_head();
        logic [31:0] unused;
        wb_access(1'b1, POP, unused);
    endtask

    // poll STATUS until it matches or the tries run out
    task automatic wait_status(input string name, input logic [31:0] exp);
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            wb_access(1'b0, STATUS, st);
            n++;
        end while (st !== exp && n < 32);
        check_val(name, exp, st);
    endtask

    task automatic check_rec(input string name, input int v);
        logic [31:0] dat;
        for (int w = 0; w < 6; w++) begin
            wb_access(1'b0, 3'(w), dat);
            check_val($sformatf("%s rec%0d", name, w), golden[v*VWORDS + 7 + w], dat);
        end
    endtask

    // fetch, then data plus load/store, then load data plus write-back
    task automatic drive_fetch(input int v);
        logic [31:0] ctl;
        int          b;
        int          gap;
        b       = v * VWORDS;
        ctl     = golden[b+2];
        ifu_vld = 1'b1;
        ifu_adr = golden[b];
        @(posedge tcb_ifu);
        #1;
        ifu_vld = 1'b0;
        ifu_rdt = golden[b+1];   // response one cycle after the transfer
        lsu_vld = ctl[0];
        lsu_rdy = ctl[0];
        lsu_wen = ctl[1];
        lsu_ren = ctl[2];
        lsu_siz = ctl[5:4];
        gpr_sid = ctl[12:8];     // store source register
        lsu_adr = golden[b+3];
        lsu_wdt = golden[b+4];
        @(posedge tcb_ifu);
        #1;
        lsu_vld = 1'b0;
        lsu_rdy = 1'b0;
        lsu_rdt = golden[b+5];
        gpr_den = ctl[16];
        gpr_did = ctl[28:24];
        gpr_ddt = golden[b+6];
        @(posedge tcb_ifu);
        #1;
        gpr_den = 1'b0;
        gap     = lcg_next() >> 30;  // idle 0 to 3 cycles
        repeat (gap) begin
            @(posedge tcb_ifu);
            #1;
        end
    endtask

    task automatic begin_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err0) $display("test %-12s ok", name);
        else $display("test %-12s %0d mismatches", name, errors - test_err0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] st;
        tcb_ifu   = 1'b0;
        rst_n     = 1'b0;
        ifu_vld   = 1'b0;
        ifu_rdy   = 1'b1;   // fetch side never stalls here
        ifu_adr   = '0;
        ifu_rdt   = '0;
        lsu_vld   = 1'b0;
        lsu_rdy   = 1'b0;
        lsu_wen   = 1'b0;
        lsu_ren   = 1'b0;
        lsu_adr   = '0;
        lsu_siz   = '0;
        lsu_wdt   = '0;
        lsu_rdt   = '0;
        gpr_den   = 1'b0;
        gpr_did   = '0;
        gpr_ddt   = '0;
        gpr_sid   = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        lcg_state = 32'he216;
        $readmemh("tests/trace_golden.hex", golden);
        if ($isunknown(golden[NVEC*VWORDS-1])) begin
            errors++;
            $display("golden file is missing or holds fewer than %0d vectors", NVEC);
        end
        repeat (16) @(posedge tcb_ifu);
        #1;
        rst_n = 1'b1;

        // empty after reset
        begin_test();
        wait_status("reset status", 32'h0);
        for (int w = 0; w < 6; w++) begin
            wb_access(1'b0, 3'(w), st);
            check_val($sformatf("reset rec%0d", w), 32'h0, st);
        end
        end_test("reset");

        // one record at a time
        for (int v = 0; v < NSOLO; v++) begin
            begin_test();
            drive_fetch(v);
            wait_status({names[v], " status"}, 32'h1);
            check_rec(names[v], v);
            pop_head();
            wait_status({names[v], " empty"}, 32'h0);
            end_test(names[v]);
        end

        // overrun, last two records dropped
        begin_test();
        for (int v = NSOLO; v < NVEC; v++) drive_fetch(v);
        wait_status("fill status", FILL_STATUS);
        for (int v = NSOLO; v < NSOLO + `TRACE_FIFO_DEPTH; v++) begin
            check_rec($sformatf("fill %0d", v - NSOLO), v);
            pop_head();
        end
        wait_status("drained status", DRAIN_STATUS);
        end_test("fifo_fill");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT) @(posedge tcb_ifu);
        $display("timeout, the run did not end within %0d cycles", LIMIT);
        $display("TB FAILED");
        $finish;
    end

endmodule: trace_unit_tb

/* tests/trace_golden.hex */
// two lines per vector, stimulus first, expected record words second
// stimulus line holds ifu_adr ifu_rdt ctl lsu_adr lsu_wdt lsu_rdt gpr_ddt
// ctl bits [0] lsu transfer [1] wen [2] ren [5:4] siz [12:8] sid [16] gpr_den [28:24] gpr_did
// record line holds pc ins wb_dat ls_adr ls_dat flags
// addi x1, x0, 5 with write-back disabled
00000100 00500093 07000000 00000000 00000000 00000000 deadbeef
00000100 00500093 00000000 00000000 00000000 00000001
// c.li a0, 3 with write-back
00000104 0001450d 0a010000 00000000 00000000 00000000 00000003
00000104 0001450d 00000003 00000000 00000000 00000054
// sw x5, 8(x2)
00000108 00512423 00000523 00002008 12345678 ffffffff 00000000
00000108 00512423 00000000 00002008 12345678 0000b303
// c.lw a1, 4(a0) with load write-back
0000010c 0001414c 0b010725 00002004 aaaaaaaa cafef00d cafef00d
0000010c 0001414c cafef00d 00002004 cafef00d 0000155e
// ten addi xk, x0, k for the fill, last two get dropped
00000200 00100093 01010000 00000000 00000000 00000000 00000001
00000200 00100093 00000001 00000000 00000000 0000000d
00000204 00200113 02010000 00000000 00000000 00000000 00000002
00000204 00200113 00000002 00000000 00000000 00000015
00000208 00300193 03010000 00000000 00000000 00000000 00000003
00000208 00300193 00000003 00000000 00000000 0000001d
0000020c 00400213 04010000 00000000 00000000 00000000 00000004
0000020c 00400213 00000004 00000000 00000000 00000025
00000210 00500293 05010000 00000000 00000000 00000000 00000005
00000210 00500293 00000005 00000000 00000000 0000002d
00000214 00600313 06010000 00000000 00000000 00000000 00000006
00000214 00600313 00000006 00000000 00000000 00000035
00000218 00700393 07010000 00000000 00000000 00000000 00000007
00000218 00700393 00000007 00000000 00000000 0000003d
0000021c 00800413 08010000 00000000 00000000 00000000 00000008
0000021c 00800413 00000008 00000000 00000000 00000045
00000220 00900493 09010000 00000000 00000000 00000000 00000009
00000220 00900493 00000009 00000000 00000000 0000004d
00000224 00a00513 0a010000 00000000 00000000 00000000 0000000a
00000224 00a00513 0000000a 00000000 00000000 00000055

/* files.f */
+incdir+verilog
verilog/tcb_pkg.sv
verilog/trace_pkg.sv
verilog/tcb_if.sv
verilog/trace_fetch_stage.sv
verilog/trace_record_builder.sv
verilog/trace_fifo.sv
verilog/trace_wb_port.sv
verilog/trace_unit_top.sv
tests/trace_unit_props.sv
tests/trace_unit_tb.sv

/* Makefile */
# Verilator build and run of the trace unit testbench
# override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= trace_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

SRCS := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS) tests/trace_golden.hex
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
